//--- project.f
hdl/ahb_mon_pkg.sv
hdl/ahb_bus_capture.sv
hdl/ahb_trans_checker.sv
hdl/ahb_addr_checker.sv
hdl/ahb_resp_checker.sv
hdl/ahb_violation_log.sv
hdl/ahb_monitor_top.sv
tests/tb_ahb_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Build the AHB monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_ahb_monitor -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation executable exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

//--- tests/tb_ahb_monitor.sv
// AHB monitor testbench
`timescale 1ns/1ps

module tb_ahb_monitor;
  import ahb_mon_pkg::*;

  localparam int          NUM_CASES       = 14;
  localparam int          MAX_BEATS       = 8;
  localparam int          SETTLE_CYCLES   = 10;
  localparam int          WATCHDOG_CYCLES = 2000;
  localparam logic [31:0] SEED            = 32'he66f91ae;

  // Short names for the table
  localparam logic WR   = 1'b1;
  localparam logic RD   = 1'b0;
  localparam logic RDY  = 1'b1;
  localparam logic WAIT = 1'b0;

  // One bus cycle of stimulus
  // Write data is drawn at run time
  typedef struct packed {
    logic [1:0]  htrans;
    logic [31:0] haddr;
    logic [2:0]  hburst;
    logic [2:0]  hsize;
    logic        hwrite;
    logic        hready;
    logic        hresp;
  } beat_t;

  logic        HCLK;
  logic        HRESETn;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic        HWRITE;
  logic [2:0]  HSIZE;
  logic [2:0]  HBURST;
  logic [1:0]  HTRANS;
  logic        HREADY;
  logic        HRESP;
  logic        clear;
  ahb_viol_t   flags;
  logic [7:0]  count;

  // Stimulus table
  string       case_name  [NUM_CASES];
  beat_t       case_beats [NUM_CASES][MAX_BEATS];
  int          case_len   [NUM_CASES];
  ahb_viol_t   case_flags [NUM_CASES];
  logic [7:0]  case_count [NUM_CASES];
  int          n_cases;

  int          error_count;
  int          checks_run;
  bit          settled;

  ahb_monitor_top DUT (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HADDR   (HADDR),
    .HWDATA  (HWDATA),
    .HWRITE  (HWRITE),
    .HSIZE   (HSIZE),
    .HBURST  (HBURST),
    .HTRANS  (HTRANS),
    .HREADY  (HREADY),
    .HRESP   (HRESP),
    .clear   (clear),
    .flags   (flags),
    .count   (count)
  );

  // 8 ns clock
  always #4 HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////
  // Table building
  ////////////////////////////////////////////////////////////

  task automatic open_case(input string name, input ahb_viol_t exp_flags,
                           input logic [7:0] exp_count);
    case_name[n_cases]  = name;
    case_flags[n_cases] = exp_flags;
    case_count[n_cases] = exp_count;
    case_len[n_cases]   = 0;
    n_cases++;
  endtask

  task automatic add_beat(input logic [1:0] htrans, input logic [31:0] haddr,
                          input logic [2:0] hburst, input logic [2:0] hsize,
                          input logic hwrite, input logic hready, input logic hresp);
    beat_t b;
    int    c;
    c = n_cases - 1;
    b = '{htrans: htrans, haddr: haddr, hburst: hburst, hsize: hsize,
          hwrite: hwrite, hready: hready, hresp: hresp};
    case_beats[c][case_len[c]] = b;
    case_len[c]++;
  endtask

  task automatic build_table();
    ahb_viol_t e;
    n_cases = 0;
    // Legal traffic raises nothing
    open_case("incr4_legal", '0, 8'd0);
    add_beat(HTRANS_NONSEQ, 32'h100, HBURST_INCR4, HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h104, HBURST_INCR4, HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h108, HBURST_INCR4, HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h10c, HBURST_INCR4, HSIZE_WORD, WR, RDY, HRESP_OKAY);
    // Wraps at the 32 byte boundary after the second beat
    open_case("wrap8_legal", '0, 8'd0);
    add_beat(HTRANS_NONSEQ, 32'h38, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h3c, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h20, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h24, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h28, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h2c, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h30, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h34, HBURST_WRAP8, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    open_case("single_wait_stable", '0, 8'd0);
    add_beat(HTRANS_NONSEQ, 32'h200, HBURST_SINGLE, HSIZE_WORD, WR, RDY,  HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h204, HBURST_SINGLE, HSIZE_WORD, RD, WAIT, HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h204, HBURST_SINGLE, HSIZE_WORD, RD, WAIT, HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h204, HBURST_SINGLE, HSIZE_WORD, RD, RDY,  HRESP_OKAY);
    // Transfer type outside a burst
    e = '0;
    e.seq_no_burst = 1'b1;
    open_case("seq_outside_burst", e, 8'd1);
    add_beat(HTRANS_IDLE, 32'h0,   HBURST_SINGLE, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,  32'h300, HBURST_INCR,   HSIZE_WORD, RD, RDY, HRESP_OKAY);
    e = '0;
    e.busy_no_burst = 1'b1;
    open_case("busy_outside_burst", e, 8'd1);
    add_beat(HTRANS_IDLE, 32'h0,   HBURST_SINGLE, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_BUSY, 32'h300, HBURST_INCR,   HSIZE_WORD, RD, RDY, HRESP_OKAY);
    // Burst cut short in fixed and in open length
    e = '0;
    e.early_term = 1'b1;
    open_case("incr4_cut_short", e, 8'd1);
    add_beat(HTRANS_NONSEQ, 32'h400, HBURST_INCR4,  HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h404, HBURST_INCR4,  HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h500, HBURST_SINGLE, HSIZE_WORD, WR, RDY, HRESP_OKAY);
    open_case("incr_ended_by_nonseq", '0, 8'd0);
    add_beat(HTRANS_NONSEQ, 32'h400, HBURST_INCR,   HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h404, HBURST_INCR,   HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h500, HBURST_SINGLE, HSIZE_WORD, WR, RDY, HRESP_OKAY);
    // Control moving during wait states
    e = '0;
    e.wait_haddr = 1'b1;
    open_case("haddr_moves_in_wait", e, 8'd1);
    add_beat(HTRANS_NONSEQ, 32'h600, HBURST_SINGLE, HSIZE_WORD, WR, RDY,  HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h604, HBURST_SINGLE, HSIZE_WORD, WR, WAIT, HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h608, HBURST_SINGLE, HSIZE_WORD, WR, RDY,  HRESP_OKAY);
    e = '0;
    e.wait_hwrite = 1'b1;
    open_case("hwrite_moves_in_wait", e, 8'd1);
    add_beat(HTRANS_NONSEQ, 32'h600, HBURST_SINGLE, HSIZE_WORD, WR, RDY,  HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h604, HBURST_SINGLE, HSIZE_WORD, WR, WAIT, HRESP_OKAY);
    add_beat(HTRANS_NONSEQ, 32'h604, HBURST_SINGLE, HSIZE_WORD, RD, RDY,  HRESP_OKAY);
    // Third beat should wrap to 0x40
    // Last beat follows on from the bad one
    e = '0;
    e.burst_addr = 1'b1;
    open_case("wrap4_bad_beat", e, 8'd1);
    add_beat(HTRANS_NONSEQ, 32'h48, HBURST_WRAP4, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h4c, HBURST_WRAP4, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h44, HBURST_WRAP4, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h48, HBURST_WRAP4, HSIZE_WORD, RD, RDY, HRESP_OKAY);
    // 64 bit beats on a 32 bit bus give one hit per beat
    e = '0;
    e.hsize_range = 1'b1;
    open_case("dword_on_word_bus", e, 8'd4);
    add_beat(HTRANS_NONSEQ, 32'h700, HBURST_INCR4, HSIZE_DWORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h708, HBURST_INCR4, HSIZE_DWORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h710, HBURST_INCR4, HSIZE_DWORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_SEQ,    32'h718, HBURST_INCR4, HSIZE_DWORD, WR, RDY, HRESP_OKAY);
    // Slave responses
    e = '0;
    e.resp_error = 1'b1;
    open_case("error_one_cycle", e, 8'd1);
    add_beat(HTRANS_NONSEQ, 32'h800, HBURST_SINGLE, HSIZE_WORD, WR, RDY, HRESP_OKAY);
    add_beat(HTRANS_IDLE,   32'h0,   HBURST_SINGLE, HSIZE_WORD, WR, RDY, HRESP_ERROR);
    e = '0;
    e.resp_idle_busy = 1'b1;
    open_case("wait_after_idle", e, 8'd1);
    add_beat(HTRANS_IDLE, 32'h0, HBURST_SINGLE, HSIZE_WORD, RD, RDY,  HRESP_OKAY);
    add_beat(HTRANS_IDLE, 32'h0, HBURST_SINGLE, HSIZE_WORD, RD, WAIT, HRESP_OKAY);
    add_beat(HTRANS_IDLE, 32'h0, HBURST_SINGLE, HSIZE_WORD, RD, RDY,  HRESP_OKAY);
    open_case("error_two_cycle", '0, 8'd0);
    add_beat(HTRANS_NONSEQ, 32'h900, HBURST_SINGLE, HSIZE_WORD, WR, RDY,  HRESP_OKAY);
    add_beat(HTRANS_IDLE,   32'h0,   HBURST_SINGLE, HSIZE_WORD, WR, WAIT, HRESP_ERROR);
    add_beat(HTRANS_IDLE,   32'h0,   HBURST_SINGLE, HSIZE_WORD, WR, RDY,  HRESP_ERROR);
  endtask

  ////////////////////////////////////////////////////////////
  // Bus driving and checking
  ////////////////////////////////////////////////////////////

  task automatic drive_bus(input beat_t b, input logic [31:0] data);
    HTRANS = b.htrans;
    HADDR  = b.haddr;
    HBURST = b.hburst;
    HSIZE  = b.hsize;
    HWRITE = b.hwrite;
    HREADY = b.hready;
    HRESP  = b.hresp;
    HWDATA = data;
  endtask

  // Idle bus with a ready OKAY response
  task automatic drive_idle();
    beat_t b;
    b = '{htrans: HTRANS_IDLE, hburst: HBURST_SINGLE, hready: 1'b1,
          hresp: HRESP_OKAY, default: '0};
    drive_bus(b, 32'h0);
  endtask

  task automatic check_case(input int c);
    checks_run++;
    if (flags !== case_flags[c])
    begin
      error_count++;
      $display("Error: %s flags expected %b actual %b", case_name[c], case_flags[c], flags);
    end
    if (count !== case_count[c])
    begin
      error_count++;
      $display("Error: %s count expected %0d actual %0d", case_name[c], case_count[c], count);
    end
  endtask

  task automatic run_case(input int c);
    beat_t       b;
    logic [31:0] data;
    logic        prev_ready;
    int          i;
    // Clear cycle with an idle bus
    @(negedge HCLK);
    clear = 1'b1;
    drive_idle();
    prev_ready = 1'b1;
    data       = '0;
    for (i = 0; i < case_len[c]; i++)
    begin
      b = case_beats[c][i];
      // Fresh data only where the last cycle was accepted
      if (prev_ready)
        data = $urandom;
      @(negedge HCLK);
      clear = 1'b0;
      drive_bus(b, data);
      prev_ready = b.hready;
    end
    // Two idle cycles flush the last judgement into the log
    repeat (2)
    begin
      @(negedge HCLK);
      drive_idle();
    end
    @(negedge HCLK);
    check_case(c);
  endtask

  // Flags and count must read zero shortly after reset
  task automatic wait_reset_settle(output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < SETTLE_CYCLES)
    begin
      @(negedge HCLK);
      ok = (flags == '0) && (count == 8'd0);
      n++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    clear       = 1'b0;
    error_count = 0;
    checks_run  = 0;
    drive_idle();
    void'($urandom(SEED));
    build_table();
    // Reset held for 5 cycles
    repeat (5) @(negedge HCLK);
    HRESETn = 1'b1;
    wait_reset_settle(settled);
    if (!settled)
    begin
      error_count++;
      $display("Monitor flags or count did not settle to zero after reset");
    end
    else
    begin
      for (int c = 0; c < n_cases; c++)
        run_case(c);
    end
    $display("Checks run %0d, errors %0d", checks_run, error_count);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // Cycle budget for the whole run
  initial
  begin
    int cyc;
    cyc = 0;
    while (cyc < WATCHDOG_CYCLES)
    begin
      @(posedge HCLK);
      cyc++;
    end
    $display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- hdl/ahb_monitor_top.sv
// AHB bus protocol monitor
`timescale 1ns/1ps

module ahb_monitor_top #(
  parameter int ADDR_SIZE   = 32,
  parameter int DATA_SIZE   = 32,
  parameter int COUNT_WIDTH = 8
) (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic [ADDR_SIZE-1:0]   HADDR,
  input  logic [DATA_SIZE-1:0]   HWDATA,
  input  logic                   HWRITE,
  input  logic [2:0]             HSIZE,
  input  logic [2:0]             HBURST,
  input  logic [1:0]             HTRANS,
  input  logic                   HREADY,
  input  logic                   HRESP,
  input  logic                   clear,
  output ahb_mon_pkg::ahb_viol_t flags,
  output logic [COUNT_WIDTH-1:0] count
);
  import ahb_mon_pkg::*;

  ahb_bus_t  cur;
  ahb_ctx_t  ctx;
  ahb_viol_t hit_trans;
  ahb_viol_t hit_addr;
  ahb_viol_t hit_resp;
  ahb_viol_t hit;

  ////////////////////////////////////////////////////////////
  // Bus sample, zero-extended into the record
  ////////////////////////////////////////////////////////////

  assign cur.haddr  = ADDR_MAX'(HADDR);
  assign cur.hwdata = DATA_MAX'(HWDATA);
  assign cur.hwrite = HWRITE;
  assign cur.hsize  = HSIZE;
  assign cur.hburst = HBURST;
  assign cur.htrans = HTRANS;
  assign cur.hready = HREADY;
  assign cur.hresp  = HRESP;

  ahb_bus_capture u_capture (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .cur     (cur),
    .ctx     (ctx)
  );

  // Checkers, each owns its own slice of the record
  ahb_trans_checker u_trans (.cur(cur), .ctx(ctx), .hit(hit_trans));

  ahb_addr_checker #(
    .ADDR_SIZE (ADDR_SIZE),
    .DATA_SIZE (DATA_SIZE)
  ) u_addr (.cur(cur), .ctx(ctx), .hit(hit_addr));

  ahb_resp_checker u_resp (.cur(cur), .ctx(ctx), .hit(hit_resp));

  assign hit = hit_trans | hit_addr | hit_resp;

  ahb_violation_log #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_log (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .clear   (clear),
    .hit     (hit),
    .flags   (flags),
    .count   (count)
  );

endmodule

//--- hdl/ahb_violation_log.sv
// AHB violation flags and counter
`timescale 1ns/1ps

module ahb_violation_log #(
  parameter int COUNT_WIDTH = 8
) (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   clear,
  input  ahb_mon_pkg::ahb_viol_t hit,
  output ahb_mon_pkg::ahb_viol_t flags,
  output logic [COUNT_WIDTH-1:0] count
);

  logic any_hit;    // At least one rule broken this cycle
  logic cnt_full;

  assign any_hit  = |hit;
  assign cnt_full = &count;

  ////////////////////////////////////////////////////////////
  // Sticky flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      flags <= '0;
    else if (clear)
      flags <= '0;   // Clear wins over hits in the same cycle
    else
      flags <= flags | hit;
  end

  ////////////////////////////////////////////////////////////
  // Offending cycles, saturating
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      count <= '0;
    else if (clear)
      count <= '0;
    else if (any_hit && !cnt_full)
      count <= count + 1'b1;
  end

endmodule

//--- hdl/ahb_resp_checker.sv
// AHB slave response checks
`timescale 1ns/1ps

module ahb_resp_checker (
  input  ahb_mon_pkg::ahb_bus_t  cur,
  input  ahb_mon_pkg::ahb_ctx_t  ctx,
  output ahb_mon_pkg::ahb_viol_t hit
);
  import ahb_mon_pkg::*;

  logic prev_idle_busy;   // IDLE or BUSY accepted on the previous edge
  logic prev_err_wait;    // First ERROR cycle seen on the previous edge
  logic cur_err_done;     // Second ERROR cycle on the bus now
  logic cur_not_zero;     // Anything but a ready OKAY

  assign prev_idle_busy = ctx.prev.hready &&
                          ((ctx.prev.htrans == HTRANS_IDLE) ||
                           (ctx.prev.htrans == HTRANS_BUSY));

  assign prev_err_wait = !ctx.prev.hready && (ctx.prev.hresp == HRESP_ERROR);
  assign cur_err_done  = cur.hready && (cur.hresp == HRESP_ERROR);
  assign cur_not_zero  = !cur.hready || (cur.hresp == HRESP_ERROR);

  always_comb
  begin
    hit = '0;
    // IDLE and BUSY get a zero-wait OKAY
    hit.resp_idle_busy = prev_idle_busy && cur_not_zero;
    // ERROR takes two cycles, not ready then ready
    hit.resp_error     = (cur_err_done && !prev_err_wait) ||
                         (prev_err_wait && !cur_err_done);
  end

endmodule

//--- hdl/ahb_addr_checker.sv
// AHB burst address and size checks
`timescale 1ns/1ps

module ahb_addr_checker #(
  parameter int ADDR_SIZE = 32,
  parameter int DATA_SIZE = 32
) (
  input  ahb_mon_pkg::ahb_bus_t  cur,
  input  ahb_mon_pkg::ahb_ctx_t  ctx,
  output ahb_mon_pkg::ahb_viol_t hit
);
  import ahb_mon_pkg::*;

  logic [ADDR_SIZE-1:0] prev_addr;
  logic [ADDR_SIZE-1:0] unit_addr;   // Previous address in transfer units
  logic [ADDR_SIZE-1:0] unit_next;
  logic [ADDR_SIZE-1:0] unit_wrap;
  logic [ADDR_SIZE-1:0] exp_addr;
  logic [10:0]          xfer_bits;

  // Width of one transfer in bits
  function automatic logic [10:0] size_bits(input logic [2:0] hsize);
    logic [10:0] n;
    case (hsize)
      HSIZE_BYTE:  n = 11'd8;
      HSIZE_HWORD: n = 11'd16;
      HSIZE_WORD:  n = 11'd32;
      HSIZE_DWORD: n = 11'd64;
      HSIZE_B128:  n = 11'd128;
      HSIZE_B256:  n = 11'd256;
      HSIZE_B512:  n = 11'd512;
      HSIZE_B1024: n = 11'd1024;
      default:     n = 11'd8;
    endcase
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Expected next address
  ////////////////////////////////////////////////////////////

  assign prev_addr = ctx.prev.haddr[ADDR_SIZE-1:0];
  assign unit_addr = prev_addr >> ctx.prev.hsize;
  assign unit_next = unit_addr + 1'b1;

  // Wrapping bursts keep the upper unit bits
  always_comb
  begin
    case (ctx.prev.hburst)
      HBURST_WRAP4:  unit_wrap = {unit_addr[ADDR_SIZE-1:2], unit_next[1:0]};
      HBURST_WRAP8:  unit_wrap = {unit_addr[ADDR_SIZE-1:3], unit_next[2:0]};
      HBURST_WRAP16: unit_wrap = {unit_addr[ADDR_SIZE-1:4], unit_next[3:0]};
      default:       unit_wrap = unit_next;
    endcase
  end

  // BUSY already shows the address of the beat that follows
  assign exp_addr = (ctx.prev.htrans == HTRANS_BUSY) ? prev_addr
                                                     : unit_wrap << ctx.prev.hsize;

  assign xfer_bits = size_bits(cur.hsize);

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    hit = '0;
    hit.burst_addr  = (cur.htrans == HTRANS_SEQ) && ctx.in_burst && ctx.prev.hready &&
                      (cur.haddr[ADDR_SIZE-1:0] != exp_addr);
    // Judged once per transfer, not again in its wait states
    hit.hsize_range = ctx.prev.hready && (cur.htrans != HTRANS_IDLE) &&
                      (int'(xfer_bits) > DATA_SIZE);
  end

endmodule

//--- hdl/ahb_trans_checker.sv
// AHB transfer and stability checks
`timescale 1ns/1ps

module ahb_trans_checker (
  input  ahb_mon_pkg::ahb_bus_t  cur,
  input  ahb_mon_pkg::ahb_ctx_t  ctx,
  output ahb_mon_pkg::ahb_viol_t hit
);
  import ahb_mon_pkg::*;

  logic new_xfer;   // First showing of this address phase
  logic in_fixed;   // Fixed burst open, last beat not yet reached
  logic cur_term;   // IDLE or NONSEQ on the bus
  logic ctrl_diff;

  // After a wait state the bus repeats the cycle already judged
  assign new_xfer = ctx.prev.hready;

  assign in_fixed = ctx.in_burst && !ctx.last_beat &&
                    (ctx.prev.hburst != HBURST_INCR);

  assign cur_term = (cur.htrans == HTRANS_IDLE) || (cur.htrans == HTRANS_NONSEQ);

  assign ctrl_diff = (cur.hsize  != ctx.prev.hsize)  ||
                     (cur.hburst != ctx.prev.hburst) ||
                     (cur.hwrite != ctx.prev.hwrite);

  always_comb
  begin
    hit = '0;

    ////////////////////////////////////////////////////////////
    // HTRANS sequencing
    ////////////////////////////////////////////////////////////
    hit.busy_no_burst = new_xfer && (cur.htrans == HTRANS_BUSY) && !ctx.in_burst;
    hit.seq_no_burst  = new_xfer && (cur.htrans == HTRANS_SEQ) && !ctx.in_burst;
    // Fixed burst cut short
    hit.early_term    = new_xfer && in_fixed && cur_term;

    ////////////////////////////////////////////////////////////
    // Wait states, everything held
    ////////////////////////////////////////////////////////////
    hit.wait_htrans = !new_xfer && (cur.htrans != ctx.prev.htrans);
    hit.wait_haddr  = !new_xfer && (cur.haddr  != ctx.prev.haddr);
    hit.wait_hsize  = !new_xfer && (cur.hsize  != ctx.prev.hsize);
    hit.wait_hburst = !new_xfer && (cur.hburst != ctx.prev.hburst);
    hit.wait_hwrite = !new_xfer && (cur.hwrite != ctx.prev.hwrite);
    hit.wait_hwdata = !new_xfer && (cur.hwdata != ctx.prev.hwdata);

    // Control fixed for the beats of a burst
    hit.burst_ctrl = new_xfer && in_fixed && !cur_term && ctrl_diff;
  end

endmodule

//--- hdl/ahb_bus_capture.sv
// AHB previous cycle and burst tracker
`timescale 1ns/1ps

module ahb_bus_capture (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_mon_pkg::ahb_bus_t cur,
  output ahb_mon_pkg::ahb_ctx_t ctx
);
  import ahb_mon_pkg::*;

  // Reset image: IDLE, ready, OKAY, all else zero
  localparam ahb_bus_t PREV_RST = '{
    htrans:  HTRANS_IDLE,
    hready:  1'b1,
    hresp:   HRESP_OKAY,
    default: '0
  };

  ahb_bus_t   prev_q;
  logic       in_burst_q;
  logic       counted_q;    // Fixed-length burst, count is live
  logic [3:0] beat_cnt_q;   // SEQ beats left before the last one
  logic       last_beat;

  // Beats left after the NONSEQ, less the final beat
  function automatic logic [3:0] beats_load(input logic [2:0] hburst);
    logic [3:0] n;
    case (hburst)
      HBURST_WRAP4, HBURST_INCR4:   n = 4'd2;
      HBURST_WRAP8, HBURST_INCR8:   n = 4'd6;
      HBURST_WRAP16, HBURST_INCR16: n = 4'd14;
      default:                      n = 4'd0;
    endcase
    return n;
  endfunction

  // INCR never counts, so it never reaches a last beat
  assign last_beat = counted_q && (beat_cnt_q == 4'd0);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prev_q     <= PREV_RST;
      in_burst_q <= 1'b0;
      counted_q  <= 1'b0;
      beat_cnt_q <= 4'd0;
    end
    else
    begin
      prev_q <= cur;
      // Address phase only moves on when the slave is ready
      if (cur.hready)
      begin
        case (cur.htrans)
          HTRANS_NONSEQ:
          begin
            in_burst_q <= (cur.hburst != HBURST_SINGLE);
            counted_q  <= (cur.hburst != HBURST_SINGLE) && (cur.hburst != HBURST_INCR);
            beat_cnt_q <= beats_load(cur.hburst);
          end
          HTRANS_SEQ:
          begin
            if (last_beat)
            begin
              in_burst_q <= 1'b0;
              counted_q  <= 1'b0;
            end
            else if (counted_q)
              beat_cnt_q <= beat_cnt_q - 4'd1;
          end
          HTRANS_IDLE:
          begin
            in_burst_q <= 1'b0;
            counted_q  <= 1'b0;
          end
          default: ;  // BUSY keeps the burst as it is
        endcase
      end
    end
  end

  assign ctx.prev      = prev_q;
  assign ctx.in_burst  = in_burst_q;
  assign ctx.last_beat = last_beat;

endmodule

//--- hdl/ahb_mon_pkg.sv
// AHB bus monitor definitions
package ahb_mon_pkg;

  ////////////////////////////////////////////////////////////
  // AHB encodings
  ////////////////////////////////////////////////////////////

  // Transfer type
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Burst type
  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_INCR   = 3'b001;
  localparam logic [2:0] HBURST_WRAP4  = 3'b010;
  localparam logic [2:0] HBURST_INCR4  = 3'b011;
  localparam logic [2:0] HBURST_WRAP8  = 3'b100;
  localparam logic [2:0] HBURST_INCR8  = 3'b101;
  localparam logic [2:0] HBURST_WRAP16 = 3'b110;
  localparam logic [2:0] HBURST_INCR16 = 3'b111;

  // Transfer size, log2 of the byte count
  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;
  localparam logic [2:0] HSIZE_DWORD = 3'b011;
  localparam logic [2:0] HSIZE_B128  = 3'b100;
  localparam logic [2:0] HSIZE_B256  = 3'b101;
  localparam logic [2:0] HSIZE_B512  = 3'b110;
  localparam logic [2:0] HSIZE_B1024 = 3'b111;

  // Slave response
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  ////////////////////////////////////////////////////////////
  // Sampled bus and burst context
  ////////////////////////////////////////////////////////////

  // Widest address and data the record can carry
  localparam int ADDR_MAX = 64;
  localparam int DATA_MAX = 1024;

  // One bus cycle as seen at a rising edge
  typedef struct packed {
    logic [ADDR_MAX-1:0] haddr;
    logic [DATA_MAX-1:0] hwdata;
    logic                hwrite;
    logic [2:0]          hsize;
    logic [2:0]          hburst;
    logic [1:0]          htrans;
    logic                hready;
    logic                hresp;
  } ahb_bus_t;

  typedef struct packed {
    ahb_bus_t prev;       // Cycle sampled on the previous edge
    logic     in_burst;
    logic     last_beat;  // Current beat closes a fixed burst
  } ahb_ctx_t;

  ////////////////////////////////////////////////////////////
  // Violation record
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    // HTRANS sequencing
    logic busy_no_burst;
    logic seq_no_burst;
    logic early_term;
    // Stability while the slave is not ready
    logic wait_htrans;
    logic wait_haddr;
    logic wait_hsize;
    logic wait_hburst;
    logic wait_hwrite;
    logic wait_hwdata;
    // Burst rules and size range
    logic burst_ctrl;
    logic burst_addr;
    logic hsize_range;
    // Slave response
    logic resp_idle_busy;
    logic resp_error;
  } ahb_viol_t;

endpackage
